// File: project.f
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/cpu.sv
sim/cpu_chk.sv
sim/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the cpu testbench with Verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f project.f \
	&& ./obj_dir/Vcpu_tb | tee sim.log \
	&& ! grep -q "SOME TESTS FAILED" sim.log \
	|| { echo "run.sh: simulation failed, see sim.log"; exit 1; }
echo "run.sh: simulation finished cleanly"

// File: sim/cpu_tb.sv
module cpu_tb;
	import cpu_pkg::*;

	// One program word and the write it should retire
	typedef struct packed {
		instr_t   instr;
		logic     exp_wr;
		reg_idx_t rd;
		word_t    value;
	} prog_row_t;

	localparam int NUM_ROWS        = 22;
	localparam int FILL_BASE       = 64;
	localparam int FILL_WORDS      = 16;
	localparam int WAIT_LIMIT      = 50;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + 200;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       run;
	logic       prog_req;
	imem_addr_t prog_addr;
	instr_t     prog_data;
	logic       prog_ack;
	logic       hlt;
	word_t      pc_out;
	wb_trace_t  trace;

	int     checks = 0;
	int     errors = 0;
	int     writes_seen = 0;
	int     late_writes = 0;
	integer seed = 21;

	// Expected values worked by hand from the ISA rules
	prog_row_t prog [NUM_ROWS] = '{
		'{16'h0100, 1'b1, 4'd1,  16'h0000},  // ADD R1,R0,R0
		'{16'hB134, 1'b1, 4'd1,  16'h0034},  // LLB R1,0x34
		'{16'hA112, 1'b1, 4'd1,  16'h1234},  // LHB R1,0x12
		'{16'h0200, 1'b1, 4'd2,  16'h0000},  // ADD R2,R0,R0
		'{16'hB205, 1'b1, 4'd2,  16'h0005},  // LLB R2,0x05
		'{16'h0312, 1'b1, 4'd3,  16'h1239},  // ADD R3,R1,R2
		'{16'h1432, 1'b1, 4'd4,  16'h1234},  // SUB R4,R3,R2, both forward paths
		'{16'h2541, 1'b1, 4'd5,  16'h0000},  // XOR R5,R4,R1
		'{16'h4623, 1'b1, 4'd6,  16'h0028},  // SLL R6,R2,3
		'{16'h9102, 1'b0, 4'd0,  16'h0000},  // SW R1,[R0+2]
		'{16'h8702, 1'b1, 4'd7,  16'h1234},  // LW R7,[R0+2]
		'{16'h0872, 1'b1, 4'd8,  16'h1239},  // ADD R8,R7,R2 load-use
		'{16'h1983, 1'b1, 4'd9,  16'h0000},  // SUB R9,R8,R3 sets Z
		'{16'hC202, 1'b0, 4'd0,  16'h0000},  // B EQ +2, taken
		'{16'h0A11, 1'b0, 4'd0,  16'h0000},  // skipped
		'{16'h0B11, 1'b0, 4'd0,  16'h0000},  // skipped
		'{16'h2C11, 1'b1, 4'd12, 16'h0000},  // XOR R12,R1,R1 sets Z
		'{16'hC001, 1'b0, 4'd0,  16'h0000},  // B NE +1, not taken
		'{16'h0D12, 1'b1, 4'd13, 16'h1239},  // ADD R13,R1,R2
		'{16'h0EDD, 1'b1, 4'd14, 16'h2472},  // ADD R14,R13,R13
		'{16'hF000, 1'b0, 4'd0,  16'h0000},  // HLT
		'{16'h0F11, 1'b0, 4'd0,  16'h0000}   // never reaches decode
	};

	cpu u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.prog_req  (prog_req),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.prog_ack  (prog_ack),
		.hlt       (hlt),
		.pc_out    (pc_out),
		.trace     (trace)
	);

	always #5 clk = ~clk;

	// Every retirement, and those after halt
	always @(posedge clk) begin
		if (trace.valid) begin
			writes_seen <= writes_seen + 1;
			if (hlt) begin
				late_writes <= late_writes + 1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	task automatic check_word(input string name, input word_t actual, input word_t expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// Full four-phase transfer of one word
	task automatic load_word(input imem_addr_t addr, input instr_t data);
		int n;
		bit acked;
		bit released;
		acked    = 1'b0;
		released = 1'b0;
		prog_addr <= addr;
		prog_data <= data;
		prog_req  <= 1'b1;
		for (n = 0; n < WAIT_LIMIT && !acked; n++) begin
			@(posedge clk);
			acked = prog_ack;
		end
		prog_req <= 1'b0;
		for (n = 0; n < WAIT_LIMIT && !released; n++) begin
			@(posedge clk);
			released = !prog_ack;
		end
		checks += 2;
		assert (acked) else begin
			errors++;
			$display("%0t: loader never raised prog_ack for address %0d", $time, addr);
		end
		assert (released) else begin
			errors++;
			$display("%0t: prog_ack stayed high after prog_req fell, address %0d", $time, addr);
		end
	endtask

	task automatic wait_trace(output bit got);
		int n;
		got = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !got; n++) begin
			@(posedge clk);
			got = trace.valid;
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin : main
		int    i;
		int    num_writes;
		bit    got;
		bit    lost;
		word_t pc_hold;
		rst_n      = 1'b0;
		run        = 1'b0;
		prog_req   = 1'b0;
		prog_addr  = '0;
		prog_data  = '0;
		num_writes = 0;
		lost       = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// Core stopped while the program goes in
		for (i = 0; i < NUM_ROWS; i++) begin
			load_word(imem_addr_t'(i), prog[i].instr);
			if (prog[i].exp_wr) begin
				num_writes++;
			end
		end
		// Spare words past the program, random contents
		for (i = 0; i < FILL_WORDS; i++) begin
			load_word(imem_addr_t'(FILL_BASE + i), instr_t'($random(seed)));
		end

		run <= 1'b1;
		// Retirements must match the table in order
		for (i = 0; i < NUM_ROWS && !lost; i++) begin
			if (prog[i].exp_wr) begin
				wait_trace(got);
				checks++;
				assert (got) else begin
					errors++;
					$display("%0t: no register write retired for program row %0d", $time, i);
				end
				lost = !got;
				if (got) begin
					check_word("trace.rd", word_t'(trace.rd), word_t'(prog[i].rd));
					check_word("trace.data", trace.data, prog[i].value);
				end
			end
		end

		// Halt follows the last write
		got = 1'b0;
		for (i = 0; i < WAIT_LIMIT && !got; i++) begin
			@(posedge clk);
			got = hlt;
		end
		checks += 2;
		assert (got) else begin
			errors++;
			$display("%0t: hlt never rose after the last register write", $time);
		end
		assert (writes_seen == num_writes) else begin
			errors++;
			$display("%0t: %0d writes retired by halt, %0d expected", $time, writes_seen,
				num_writes);
		end
		pc_hold = pc_out;
		repeat (10) @(posedge clk);
		check_word("pc_out", pc_out, pc_hold);
		checks++;
		assert (late_writes == 0) else begin
			errors++;
			$display("%0t: %0d register writes retired after hlt", $time, late_writes);
		end

		// Requests while running get no ack
		prog_addr <= '0;
		prog_data <= 16'hFFFF;
		prog_req  <= 1'b1;
		repeat (6) begin
			@(posedge clk);
			checks++;
			assert (!prog_ack) else begin
				errors++;
				$display("%0t: loader acked a request while run was high", $time);
			end
		end
		prog_req <= 1'b0;
		@(posedge clk);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Bounded by the program length
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: sim/cpu_chk.sv
module cpu_chk (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            prog_req,
	input  logic            prog_ack,
	input  logic            stall,
	input  logic            flush,
	input  cpu_pkg::instr_t ex_instr,
	input  logic            hlt
);
	import cpu_pkg::*;

	// ------------------------------------------------------------------
	// Loader handshake
	// ------------------------------------------------------------------
	// Ack only answers a request that was already up
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(prog_ack) |-> $past(prog_req))
		else $error("prog_ack rose without a pending prog_req");

	// ------------------------------------------------------------------
	// Pipeline control
	// ------------------------------------------------------------------
	// Load-use hold puts a bubble into execute
	stall_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> (ex_instr == NOP_INSTR))
		else $error("stall did not put a bubble into execute");

	// Taken branch squashes the decode slot
	flush_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> (ex_instr == NOP_INSTR))
		else $error("branch flush did not put a bubble into execute");

	// Sticky until reset
	hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		hlt |=> hlt)
		else $error("hlt fell without a reset");

endmodule

// Fetch side sees only the handshake
bind fetch_stage cpu_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.prog_req (prog_req),
	.prog_ack (prog_ack),
	.stall    (1'b0),
	.flush    (1'b0),
	.ex_instr (16'h0000),
	.hlt      (1'b0)
);

bind hazard_unit cpu_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.prog_req (1'b0),
	.prog_ack (1'b0),
	.stall    (stall),
	.flush    (flush),
	.ex_instr (id_ex.instr),
	.hlt      (hlt)
);

// File: rtl/cpu.sv
module cpu (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                prog_req,
	input  cpu_pkg::imem_addr_t prog_addr,
	input  cpu_pkg::instr_t     prog_data,
	output logic                prog_ack,
	output logic                hlt,
	output cpu_pkg::word_t      pc_out,
	output cpu_pkg::wb_trace_t  trace
);
	import cpu_pkg::*;

	// Stage to stage registers
	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	mem_wb_t  mem_wb;

	// Hazard control
	logic     stall;
	logic     flush;
	logic     halt_drain;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	// Branch back to fetch
	logic     branch_taken;
	word_t    branch_target;

	// Decode sources seen by the hazard unit
	reg_idx_t rs;
	reg_idx_t rt;
	logic     is_halt_id;

	// ------------------------------------------------------------------
	// Stages
	// ------------------------------------------------------------------
	fetch_stage u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.run           (run),
		.stall         (stall),
		.flush         (flush),
		.halt_drain    (halt_drain),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.prog_req      (prog_req),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.prog_ack      (prog_ack),
		.pc            (pc_out),
		.if_id         (if_id)
	);

	decode_stage u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.flush      (flush),
		.if_id      (if_id),
		.wb         (mem_wb),
		.id_ex      (id_ex),
		.rs         (rs),
		.rt         (rt),
		.is_halt_id (is_halt_id)
	);

	execute_stage u_execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.id_ex         (id_ex),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.ex_mem        (ex_mem),
		.mem_wb        (mem_wb),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	memory_stage u_memory (
		.clk    (clk),
		.rst_n  (rst_n),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb)
	);

	hazard_unit u_hazard (
		.clk          (clk),
		.rst_n        (rst_n),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.rs           (rs),
		.rt           (rt),
		.is_halt_id   (is_halt_id),
		.branch_taken (branch_taken),
		.stall        (stall),
		.flush        (flush),
		.halt_drain   (halt_drain),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.hlt          (hlt)
	);

	// Writeback trace, R0 writes never set reg_write
	assign trace.valid = mem_wb.reg_write;
	assign trace.rd    = mem_wb.rd;
	assign trace.data  = mem_wb.wb_data;

endmodule

// File: rtl/hazard_unit.sv
module hazard_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::id_ex_t   id_ex,
	input  cpu_pkg::ex_mem_t  ex_mem,
	input  cpu_pkg::mem_wb_t  mem_wb,
	input  cpu_pkg::reg_idx_t rs,
	input  cpu_pkg::reg_idx_t rt,
	input  logic              is_halt_id,
	input  logic              branch_taken,
	output logic              stall,
	output logic              flush,
	output logic              halt_drain,
	output cpu_pkg::fwd_sel_t fwd_a,
	output cpu_pkg::fwd_sel_t fwd_b,
	output logic              hlt
);
	import cpu_pkg::*;

	logic halt_seen;
	logic halt_now;
	logic hlt_q;

	// Newest producer wins
	function automatic fwd_sel_t pick(reg_idx_t src, ex_mem_t m, mem_wb_t w);
		fwd_sel_t sel;
		if (m.reg_write && (m.rd != '0) && (m.rd == src)) begin
			sel = FWD_MEM;
		end else if (w.reg_write && (w.rd != '0) && (w.rd == src)) begin
			sel = FWD_WB;
		end else begin
			sel = FWD_REG;
		end
		return sel;
	endfunction

	assign fwd_a = pick(id_ex.rs, ex_mem, mem_wb);
	assign fwd_b = pick(id_ex.rt, ex_mem, mem_wb);

	// Load in execute feeding decode, R0 never matches
	assign stall = id_ex.mem_read && (id_ex.rd != '0) &&
		((id_ex.rd == rs) || (id_ex.rd == rt));

	assign flush = branch_taken;

	// ------------------------------------------------------------------
	// Halt
	// ------------------------------------------------------------------
	// HLT on a squashed path does not count
	assign halt_now   = is_halt_id && !branch_taken;
	assign halt_drain = halt_seen || halt_now;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt_seen <= 1'b0;
			hlt_q     <= 1'b0;
		end else begin
			halt_seen <= halt_drain;
			hlt_q     <= hlt_q || mem_wb.is_halt;
		end
	end

	// High from the cycle HLT sits in writeback
	assign hlt = hlt_q || mem_wb.is_halt;

endmodule

// File: rtl/memory_stage.sv
module memory_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::ex_mem_t  ex_mem,
	output cpu_pkg::mem_wb_t  mem_wb
);
	import cpu_pkg::*;

	word_t      dmem [DMEM_DEPTH];
	dmem_addr_t dmem_idx;
	word_t      load_data;

	// ------------------------------------------------------------------
	// Data memory
	// ------------------------------------------------------------------
	// Byte address to word index
	assign dmem_idx  = ex_mem.mem_addr[8:1];
	// Combinational read
	assign load_data = dmem[dmem_idx];

	always_ff @(posedge clk) begin
		if (ex_mem.mem_write) begin
			dmem[dmem_idx] <= ex_mem.store_data;
		end
	end

	// ------------------------------------------------------------------
	// MEM/WB register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			// Loads return memory, everything else the execute result
			mem_wb.wb_data   <= ex_mem.mem_read ? load_data : ex_mem.result;
			mem_wb.rd        <= ex_mem.rd;
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.is_halt   <= ex_mem.is_halt;
		end
	end

endmodule

// File: rtl/execute_stage.sv
module execute_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::id_ex_t    id_ex,
	input  cpu_pkg::fwd_sel_t  fwd_a,
	input  cpu_pkg::fwd_sel_t  fwd_b,
	output cpu_pkg::ex_mem_t   ex_mem,
	input  cpu_pkg::mem_wb_t   mem_wb,
	output logic               branch_taken,
	output cpu_pkg::word_t     branch_target
);
	import cpu_pkg::*;

	word_t  op_a;
	word_t  op_b;
	word_t  result;
	logic   ovf;
	logic   set_all;
	logic   set_z;
	flags_t flags_q;
	flags_t flags_new;
	word_t  ls_offset;
	word_t  br_offset;
	word_t  mem_addr;
	cond_t  cond;
	logic   cond_met;

	// Operand source select
	function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
			word_t wb_val);
		word_t val;
		case (sel)
			FWD_MEM: val = mem_val;
			FWD_WB:  val = wb_val;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	assign op_a = fwd_mux(fwd_a, id_ex.rs_data, ex_mem.result, mem_wb.wb_data);
	assign op_b = fwd_mux(fwd_b, id_ex.rt_data, ex_mem.result, mem_wb.wb_data);

	// ------------------------------------------------------------------
	// ALU and byte loads
	// ------------------------------------------------------------------
	always_comb begin
		result  = '0;
		ovf     = 1'b0;
		set_all = 1'b0;
		set_z   = 1'b0;
		case (id_ex.opcode)
			OP_ADD: begin
				result  = op_a + op_b;
				ovf     = (op_a[15] == op_b[15]) && (result[15] != op_a[15]);
				set_all = 1'b1;
			end
			OP_SUB: begin
				result  = op_a - op_b;
				ovf     = (op_a[15] != op_b[15]) && (result[15] != op_a[15]);
				set_all = 1'b1;
			end
			OP_XOR: begin
				result = op_a ^ op_b;
				set_z  = 1'b1;
			end
			// Shift amount is the 4-bit immediate
			OP_SLL: begin
				result = op_a << id_ex.instr[3:0];
				set_z  = 1'b1;
			end
			OP_LLB: result = {op_a[15:8], id_ex.instr[7:0]};
			OP_LHB: result = {id_ex.instr[7:0], op_a[7:0]};
			default: result = op_a;
		endcase
	end

	// ------------------------------------------------------------------
	// Flag register
	// ------------------------------------------------------------------
	always_comb begin
		flags_new = flags_q;
		// Bubbles share the NOP encoding and leave flags alone
		if (id_ex.instr != NOP_INSTR) begin
			if (set_all || set_z) begin
				flags_new[FLAG_Z] = (result == '0);
			end
			if (set_all) begin
				flags_new[FLAG_V] = ovf;
				flags_new[FLAG_N] = result[15];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else begin
			flags_q <= flags_new;
		end
	end

	// ------------------------------------------------------------------
	// Branch decision
	// ------------------------------------------------------------------
	assign cond = id_ex.instr[11:9];

	always_comb begin
		case (cond)
			COND_NE: cond_met = !flags_q[FLAG_Z];
			COND_EQ: cond_met = flags_q[FLAG_Z];
			COND_GT: cond_met = !flags_q[FLAG_Z] && !flags_q[FLAG_N];
			COND_LT: cond_met = flags_q[FLAG_N];
			COND_GE: cond_met = flags_q[FLAG_Z] || !flags_q[FLAG_N];
			COND_LE: cond_met = flags_q[FLAG_Z] || flags_q[FLAG_N];
			COND_OV: cond_met = flags_q[FLAG_V];
			default: cond_met = 1'b1;
		endcase
	end

	// Word offsets, both scaled to bytes
	assign br_offset = {{6{id_ex.instr[8]}}, id_ex.instr[8:0], 1'b0};
	assign ls_offset = {{11{id_ex.instr[3]}}, id_ex.instr[3:0], 1'b0};

	assign branch_taken  = (id_ex.opcode == OP_B) && cond_met;
	assign branch_target = id_ex.pc_next + br_offset;

	// Base register comes in on operand b
	assign mem_addr = (op_b & 16'hFFFE) + ls_offset;

	// ------------------------------------------------------------------
	// EX/MEM register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.result     <= result;
			ex_mem.mem_addr   <= mem_addr;
			ex_mem.store_data <= op_a;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.mem_read   <= id_ex.mem_read;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.is_halt    <= id_ex.is_halt;
		end
	end

endmodule

// File: rtl/decode_stage.sv
module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              flush,
	input  cpu_pkg::if_id_t   if_id,
	input  cpu_pkg::mem_wb_t  wb,
	output cpu_pkg::id_ex_t   id_ex,
	output cpu_pkg::reg_idx_t rs,
	output cpu_pkg::reg_idx_t rt,
	output logic              is_halt_id
);
	import cpu_pkg::*;

	opcode_t  opcode;
	reg_idx_t rd;
	logic     src_from_rd;
	logic     is_mem;
	logic     writes_reg;
	word_t    regs [16];
	word_t    rs_data;
	word_t    rt_data;

	// Register read with R0 pinned and writeback bypass
	function automatic word_t rf_read(reg_idx_t idx, word_t stored, mem_wb_t w);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (w.reg_write && (w.rd == idx)) begin
			val = w.wb_data;
		end else begin
			val = stored;
		end
		return val;
	endfunction

	// ------------------------------------------------------------------
	// Field decode
	// ------------------------------------------------------------------
	assign opcode = opcode_t'(if_id.instr[15:12]);
	assign rd     = if_id.instr[11:8];

	// SW data, LLB and LHB merge source sit in the rd field
	assign src_from_rd = (opcode == OP_SW) || (opcode == OP_LLB) || (opcode == OP_LHB);
	assign is_mem      = (opcode == OP_LW) || (opcode == OP_SW);

	assign rs = src_from_rd ? if_id.instr[11:8] : if_id.instr[7:4];
	// Base register of a load or store goes on the second port
	assign rt = is_mem ? if_id.instr[7:4] : if_id.instr[3:0];

	always_comb begin
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR, OP_SLL,
			OP_LW, OP_LLB, OP_LHB: writes_reg = 1'b1;
			default:               writes_reg = 1'b0;
		endcase
	end

	assign is_halt_id = (opcode == OP_HLT);

	// ------------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------------
	// reg_write is never set for R0
	always_ff @(posedge clk) begin
		if (wb.reg_write) begin
			regs[wb.rd] <= wb.wb_data;
		end
	end

	assign rs_data = rf_read(rs, regs[rs], wb);
	assign rt_data = rf_read(rt, regs[rt], wb);

	// ------------------------------------------------------------------
	// ID/EX register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || stall || flush) begin
			// Bubble is the all-zero NOP with no side effects
			id_ex <= '0;
		end else begin
			id_ex.pc_next   <= if_id.pc_next;
			id_ex.instr     <= if_id.instr;
			id_ex.opcode    <= opcode;
			id_ex.rs_data   <= rs_data;
			id_ex.rt_data   <= rt_data;
			id_ex.rs        <= rs;
			id_ex.rt        <= rt;
			id_ex.rd        <= rd;
			id_ex.reg_write <= writes_reg && (rd != '0);
			id_ex.mem_read  <= (opcode == OP_LW);
			id_ex.mem_write <= (opcode == OP_SW);
			id_ex.is_halt   <= is_halt_id;
		end
	end

endmodule

// File: rtl/fetch_stage.sv
module fetch_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                stall,
	input  logic                flush,
	input  logic                halt_drain,
	input  logic                branch_taken,
	input  cpu_pkg::word_t      branch_target,
	input  logic                prog_req,
	input  cpu_pkg::imem_addr_t prog_addr,
	input  cpu_pkg::instr_t     prog_data,
	output logic                prog_ack,
	output cpu_pkg::word_t      pc,
	output cpu_pkg::if_id_t     if_id
);
	import cpu_pkg::*;

	// Four-phase loader states
	typedef enum logic [1:0] {LD_IDLE, LD_ACK, LD_WAIT_DROP} ld_state_t;

	ld_state_t  ld_state;
	logic       ld_write;
	logic       run_q;
	instr_t     imem [IMEM_DEPTH];
	imem_addr_t pc_idx;
	word_t      pc_plus_2;

	// ------------------------------------------------------------------
	// Program loader
	// ------------------------------------------------------------------
	// Only accept a word while the core is stopped
	assign ld_write = (ld_state == LD_IDLE) && prog_req && !run;
	assign prog_ack = (ld_state == LD_ACK);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ld_state <= LD_IDLE;
		end else begin
			case (ld_state)
				LD_IDLE: begin
					if (ld_write) begin
						ld_state <= LD_ACK;
					end
				end
				// Ack held until host releases req
				LD_ACK: begin
					if (!prog_req) begin
						ld_state <= LD_WAIT_DROP;
					end
				end
				// Return-to-zero phase, one guard cycle
				default: begin
					ld_state <= LD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ld_write) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// ------------------------------------------------------------------
	// PC
	// ------------------------------------------------------------------
	// Fetch starts the cycle after run is sampled high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_q <= 1'b0;
		end else begin
			run_q <= run;
		end
	end

	// Word index, bit 0 of the byte PC is always clear
	assign pc_idx    = pc[8:1];
	assign pc_plus_2 = pc + 16'd2;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (run_q && !stall && !halt_drain) begin
			pc <= pc_plus_2;
		end
	end

	// IF/ID, stall must win over drain so a held HLT is not lost
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_id.pc_next <= '0;
			if_id.instr   <= NOP_INSTR;
		end else if (flush) begin
			if_id.instr <= NOP_INSTR;
		end else if (stall) begin
			if_id <= if_id;
		end else if (halt_drain || !run_q) begin
			if_id.instr <= NOP_INSTR;
		end else begin
			if_id.pc_next <= pc_plus_2;
			if_id.instr   <= imem[pc_idx];
		end
	end

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

	// ------------------------------------------------------------------
	// Widths with a meaning
	// ------------------------------------------------------------------
	typedef logic [15:0] word_t;
	typedef logic [15:0] instr_t;
	typedef logic [3:0]  reg_idx_t;
	// Z, V, N from msb down
	typedef logic [2:0]  flags_t;
	typedef logic [2:0]  cond_t;
	typedef logic [7:0]  imem_addr_t;
	typedef logic [7:0]  dmem_addr_t;

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	// ADD R0, R0, R0 doubles as the pipeline bubble
	localparam instr_t NOP_INSTR = 16'h0000;

	// Flag bit positions
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// Branch conditions, carried in instr[11:9]
	localparam cond_t COND_NE = 3'd0;
	localparam cond_t COND_EQ = 3'd1;
	localparam cond_t COND_GT = 3'd2;
	localparam cond_t COND_LT = 3'd3;
	localparam cond_t COND_GE = 3'd4;
	localparam cond_t COND_LE = 3'd5;
	localparam cond_t COND_OV = 3'd6;
	localparam cond_t COND_UN = 3'd7;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_SLL = 4'h4,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_HLT = 4'hF
	} opcode_t;

	// Execute operand source
	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

	// ------------------------------------------------------------------
	// Pipeline registers
	// ------------------------------------------------------------------
	typedef struct packed {
		word_t  pc_next;
		instr_t instr;
	} if_id_t;

	typedef struct packed {
		word_t    pc_next;
		instr_t   instr;
		opcode_t  opcode;
		word_t    rs_data;
		word_t    rt_data;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     is_halt;
	} id_ex_t;

	typedef struct packed {
		word_t    result;
		word_t    mem_addr;
		word_t    store_data;
		reg_idx_t rd;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     is_halt;
	} ex_mem_t;

	typedef struct packed {
		word_t    wb_data;
		reg_idx_t rd;
		logic     reg_write;
		logic     is_halt;
	} mem_wb_t;

	// One retired register write
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_trace_t;

endpackage
